/* hw/core_isa_pkg.sv */
package core_isa_pkg;

    localparam int unsigned XLEN   = 32;
    localparam int unsigned REG_AW = 5;

    // instruction field positions
    localparam int unsigned OPC_LSB = 0;
    localparam int unsigned RD_LSB  = 7;
    localparam int unsigned F3_LSB  = 12;
    localparam int unsigned RS1_LSB = 15;
    localparam int unsigned RS2_LSB = 20;
    localparam int unsigned F7_LSB  = 25;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // funct3 of the register ops, ADDI shares F3_ADD
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

endpackage

/* hw/core_cfg_pkg.sv */
package core_cfg_pkg;

    localparam int unsigned IMEM_WORDS = 64;
    localparam int unsigned DMEM_WORDS = 64;

    // word address widths
    localparam int unsigned IMEM_AW = $clog2(IMEM_WORDS);
    localparam int unsigned DMEM_AW = $clog2(DMEM_WORDS);

    localparam logic [IMEM_AW-1:0] RESET_PC = '0;

endpackage

/* hw/instr_mem.sv */
`timescale 1ns/1ps

module instr_mem (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [core_cfg_pkg::IMEM_AW-1:0] addr,
    input  logic                             load_req,
    input  logic [core_cfg_pkg::IMEM_AW-1:0] load_addr,
    input  logic [core_isa_pkg::XLEN-1:0]    load_data,
    output logic [core_isa_pkg::XLEN-1:0]    dout,
    output logic                             load_ack
);
    import core_cfg_pkg::*;

    typedef enum logic {
        LD_IDLE,
        LD_ACK
    } load_state_e;

    load_state_e state;
    logic [$bits(dout)-1:0] mem [IMEM_WORDS];

    // program load is only served while the core is held in reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= LD_IDLE;
        end else begin
            case (state)
                LD_IDLE: if (load_req) state <= LD_ACK;
                LD_ACK:  if (!load_req) state <= LD_IDLE;
                default: state <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst && state == LD_IDLE && load_req) begin
            mem[load_addr] <= load_data;
        end
    end

    // no-op word until the first fetch after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= '0;
        end else begin
            dout <= mem[addr];
        end
    end

    assign load_ack = (state == LD_ACK);

endmodule

/* hw/decode.sv */
`timescale 1ns/1ps

module decode (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [core_isa_pkg::XLEN-1:0]      instr_raw,
    input  logic                               stall,
    output logic [core_isa_pkg::REG_AW-1:0]    reg1_addr,
    output logic [core_isa_pkg::REG_AW-1:0]    reg2_addr,
    output logic                               read_reg1,
    output logic                               read_reg2,
    output logic [core_isa_pkg::XLEN-1:0]      imm,
    output core_isa_pkg::alu_op_e              alu_op,
    output logic                               src_imm,
    output logic [core_isa_pkg::REG_AW-1:0]    write_reg,
    output logic                               reg_write,
    output logic                               mem_write,
    output logic                               mem_read
);
    import core_isa_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            op_legal;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;

    alu_op_e         alu_op_d;
    logic [XLEN-1:0] imm_d;
    logic            src_imm_d;
    logic            read1_d;
    logic            read2_d;
    logic            reg_write_d;
    logic            mem_write_d;
    logic            mem_read_d;

    logic            reg_write_q;
    logic            mem_write_q;
    logic            mem_read_q;

    assign opcode = opcode_e'(instr_raw[OPC_LSB +: 7]);
    assign funct3 = instr_raw[F3_LSB +: 3];
    assign funct7 = instr_raw[F7_LSB +: 7];
    assign imm_i  = {{(XLEN-12){instr_raw[XLEN-1]}}, instr_raw[RS2_LSB +: 12]};
    assign imm_s  = {{(XLEN-12){instr_raw[XLEN-1]}}, instr_raw[F7_LSB +: 7],
                     instr_raw[RD_LSB +: 5]};

    // SUB is the only funct7 variant in the subset
    assign op_legal = (funct7 == F7_BASE) || (funct7 == F7_SUB && funct3 == F3_ADD);

    always_comb begin
        alu_op_d    = ALU_ADD;
        imm_d       = imm_i;
        src_imm_d   = 1'b1;
        read1_d     = 1'b0;
        read2_d     = 1'b0;
        reg_write_d = 1'b0;
        mem_write_d = 1'b0;
        mem_read_d  = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == F3_ADD) begin
                    read1_d     = 1'b1;
                    reg_write_d = 1'b1;
                end
            end
            OPC_LOAD: begin
                if (funct3 == F3_WORD) begin
                    read1_d     = 1'b1;
                    reg_write_d = 1'b1;
                    mem_read_d  = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_WORD) begin
                    imm_d       = imm_s;
                    read1_d     = 1'b1;
                    read2_d     = 1'b1;
                    mem_write_d = 1'b1;
                end
            end
            OPC_OP: begin
                src_imm_d   = 1'b0;
                read1_d     = op_legal;
                read2_d     = op_legal;
                reg_write_d = op_legal;
                case (funct3_e'(funct3))
                    F3_ADD:  alu_op_d = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:  alu_op_d = ALU_SLT;
                    F3_XOR:  alu_op_d = ALU_XOR;
                    F3_OR:   alu_op_d = ALU_OR;
                    F3_AND:  alu_op_d = ALU_AND;
                    default: begin
                        read1_d     = 1'b0;
                        read2_d     = 1'b0;
                        reg_write_d = 1'b0;
                    end
                endcase
            end
            default: ;
        endcase
    end

    // ID/EX control, held while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            reg1_addr   <= '0;
            reg2_addr   <= '0;
            read_reg1   <= 1'b0;
            read_reg2   <= 1'b0;
            reg_write_q <= 1'b0;
            mem_write_q <= 1'b0;
            mem_read_q  <= 1'b0;
        end else if (!stall) begin
            reg1_addr   <= instr_raw[RS1_LSB +: REG_AW];
            reg2_addr   <= instr_raw[RS2_LSB +: REG_AW];
            read_reg1   <= read1_d;
            read_reg2   <= read2_d;
            reg_write_q <= reg_write_d;
            mem_write_q <= mem_write_d;
            mem_read_q  <= mem_read_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            imm       <= imm_d;
            alu_op    <= alu_op_d;
            src_imm   <= src_imm_d;
            write_reg <= instr_raw[RD_LSB +: REG_AW];
        end
    end

    // stalled instruction stays here, EX sees a bubble
    assign reg_write = reg_write_q && !stall;
    assign mem_write = mem_write_q && !stall;
    assign mem_read  = mem_read_q && !stall;

endmodule

/* hw/exec.sv */
`timescale 1ns/1ps

module exec (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [core_isa_pkg::XLEN-1:0]   imm,
    input  core_isa_pkg::alu_op_e           alu_op,
    input  logic                            src_imm,
    input  logic [core_isa_pkg::REG_AW-1:0] reg1_addr,
    input  logic [core_isa_pkg::REG_AW-1:0] reg2_addr,
    input  logic [core_isa_pkg::XLEN-1:0]   reg1_data,
    input  logic [core_isa_pkg::XLEN-1:0]   reg2_data,
    input  logic [core_isa_pkg::REG_AW-1:0] write_reg_in,
    input  logic                            reg_write_in,
    input  logic                            mem_write_in,
    input  logic                            mem_read_in,
    input  logic [core_isa_pkg::REG_AW-1:0] write_reg_wb,
    input  logic [core_isa_pkg::XLEN-1:0]   result_wb,
    input  logic                            reg_write_wb,
    output logic [core_isa_pkg::XLEN-1:0]   result,
    output logic [core_isa_pkg::XLEN-1:0]   mem_write_data,
    output logic [core_isa_pkg::REG_AW-1:0] write_reg_out,
    output logic                            reg_write_out,
    output logic                            mem_write_out,
    output logic                            mem_read_out
);
    import core_isa_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;

    // EX/MEM wins over write-back, x0 never forwarded
    function automatic logic [XLEN-1:0] forward(input logic [REG_AW-1:0] src,
                                                input logic [XLEN-1:0]   rf_val);
        if (src == '0) begin
            return rf_val;
        end else if (reg_write_out && write_reg_out == src) begin
            return result;
        end else if (reg_write_wb && write_reg_wb == src) begin
            return result_wb;
        end
        return rf_val;
    endfunction

    always_comb begin
        op_a = forward(reg1_addr, reg1_data);
        op2  = forward(reg2_addr, reg2_data);
        op_b = src_imm ? imm : op2;
        case (alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_out <= 1'b0;
            mem_write_out <= 1'b0;
            mem_read_out  <= 1'b0;
        end else begin
            reg_write_out <= reg_write_in;
            mem_write_out <= mem_write_in;
            mem_read_out  <= mem_read_in;
        end
    end

    always_ff @(posedge clk) begin
        result         <= alu_res;
        mem_write_data <= op2;
        write_reg_out  <= write_reg_in;
    end

endmodule

/* hw/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic                             clk,
    input  logic                             en,
    input  logic                             we,
    input  logic [core_cfg_pkg::DMEM_AW-1:0] addr,
    input  logic [core_isa_pkg::XLEN-1:0]    di,
    output logic [core_isa_pkg::XLEN-1:0]    dout
);
    import core_cfg_pkg::*;

    logic [$bits(di)-1:0] mem [DMEM_WORDS];

    // read-first, data valid the cycle after en
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= di;
            end
            dout <= mem[addr];
        end
    end

endmodule

/* hw/registerfile.sv */
`timescale 1ns/1ps

module registerfile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [core_isa_pkg::REG_AW-1:0] read1,
    input  logic [core_isa_pkg::REG_AW-1:0] read2,
    input  logic [core_isa_pkg::REG_AW-1:0] write_reg,
    input  logic [core_isa_pkg::XLEN-1:0]   write_data,
    input  logic                            reg_write,
    output logic [core_isa_pkg::XLEN-1:0]   data1,
    output logic [core_isa_pkg::XLEN-1:0]   data2,
    output logic [core_isa_pkg::XLEN-1:0]   x1_test
);
    import core_isa_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];
    logic            wr_live;

    // x0 is never written
    assign wr_live = reg_write && (write_reg != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[write_reg] <= write_data;
        end
    end

    // same-cycle write passes through
    assign data1   = (wr_live && write_reg == read1) ? write_data : regs[read1];
    assign data2   = (wr_live && write_reg == read2) ? write_data : regs[read2];
    assign x1_test = regs[1];

endmodule

/* hw/core.sv */
`timescale 1ns/1ps

module core (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load_req,
    input  logic [core_cfg_pkg::IMEM_AW-1:0] load_addr,
    input  logic [core_isa_pkg::XLEN-1:0]    load_data,
    output logic                             load_ack,
    output logic [core_isa_pkg::XLEN-1:0]    test
);
    import core_isa_pkg::*;
    import core_cfg_pkg::*;

    logic [IMEM_AW-1:0] pc;
    logic [IMEM_AW-1:0] pc_cache;
    logic [IMEM_AW-1:0] pc_fetch;
    logic [XLEN-1:0]    instr_raw;
    logic               stall;

    logic [REG_AW-1:0]  reg1_addr;
    logic [REG_AW-1:0]  reg2_addr;
    logic               read_reg1;
    logic               read_reg2;
    logic [XLEN-1:0]    imm;
    alu_op_e            alu_op;
    logic               src_imm;
    logic [REG_AW-1:0]  write_reg_ex;
    logic               reg_write_ex;
    logic               mem_write_ex;
    logic               mem_read_ex;
    logic [XLEN-1:0]    reg1_data;
    logic [XLEN-1:0]    reg2_data;

    logic [XLEN-1:0]    result_mem;
    logic [XLEN-1:0]    store_data;
    logic [REG_AW-1:0]  write_reg_mem;
    logic               reg_write_mem;
    logic               mem_write_mem;
    logic               mem_read_mem;
    logic [DMEM_AW-1:0] dmem_addr;
    logic [XLEN-1:0]    ram_dout;

    logic [XLEN-1:0]    result_wb;
    logic [REG_AW-1:0]  write_reg_wb;
    logic               reg_write_wb;
    logic               mem_read_wb;
    logic [XLEN-1:0]    wb_data;

    // refetch the decode-stage word while stalled
    assign pc_fetch = stall ? pc_cache : pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= RESET_PC;
            pc_cache <= RESET_PC;
        end else begin
            // stop on the last word, the program tail is no-ops
            if (!stall && pc != IMEM_AW'(IMEM_WORDS - 1)) begin
                pc <= pc + 1'b1;
            end
            pc_cache <= pc_fetch;
        end
    end

    instr_mem imem (
        .clk       (clk),
        .rst       (rst),
        .addr      (pc_fetch),
        .load_req  (load_req),
        .load_addr (load_addr),
        .load_data (load_data),
        .dout      (instr_raw),
        .load_ack  (load_ack)
    );

    decode dec (
        .clk       (clk),
        .rst       (rst),
        .instr_raw (instr_raw),
        .stall     (stall),
        .reg1_addr (reg1_addr),
        .reg2_addr (reg2_addr),
        .read_reg1 (read_reg1),
        .read_reg2 (read_reg2),
        .imm       (imm),
        .alu_op    (alu_op),
        .src_imm   (src_imm),
        .write_reg (write_reg_ex),
        .reg_write (reg_write_ex),
        .mem_write (mem_write_ex),
        .mem_read  (mem_read_ex)
    );

    registerfile rf (
        .clk        (clk),
        .rst        (rst),
        .read1      (reg1_addr),
        .read2      (reg2_addr),
        .write_reg  (write_reg_wb),
        .write_data (wb_data),
        .reg_write  (reg_write_wb),
        .data1      (reg1_data),
        .data2      (reg2_data),
        .x1_test    (test)
    );

    exec ex (
        .clk            (clk),
        .rst            (rst),
        .imm            (imm),
        .alu_op         (alu_op),
        .src_imm        (src_imm),
        .reg1_addr      (reg1_addr),
        .reg2_addr      (reg2_addr),
        .reg1_data      (reg1_data),
        .reg2_data      (reg2_data),
        .write_reg_in   (write_reg_ex),
        .reg_write_in   (reg_write_ex),
        .mem_write_in   (mem_write_ex),
        .mem_read_in    (mem_read_ex),
        .write_reg_wb   (write_reg_wb),
        .result_wb      (wb_data),
        .reg_write_wb   (reg_write_wb),
        .result         (result_mem),
        .mem_write_data (store_data),
        .write_reg_out  (write_reg_mem),
        .reg_write_out  (reg_write_mem),
        .mem_write_out  (mem_write_mem),
        .mem_read_out   (mem_read_mem)
    );

    // load data is one cycle late for the instruction right behind it
    assign stall = mem_read_mem &&
                   ((read_reg1 && reg1_addr != '0 && reg1_addr == write_reg_mem) ||
                    (read_reg2 && reg2_addr != '0 && reg2_addr == write_reg_mem));

    // byte address to word index
    assign dmem_addr = result_mem[DMEM_AW+1:2];

    data_ram dmem (
        .clk  (clk),
        .en   (mem_read_mem || mem_write_mem),
        .we   (mem_write_mem),
        .addr (dmem_addr),
        .di   (store_data),
        .dout (ram_dout)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_wb <= 1'b0;
            mem_read_wb  <= 1'b0;
        end else begin
            reg_write_wb <= reg_write_mem;
            mem_read_wb  <= mem_read_mem;
        end
    end

    always_ff @(posedge clk) begin
        result_wb    <= result_mem;
        write_reg_wb <= write_reg_mem;
    end

    assign wb_data = mem_read_wb ? ram_dout : result_wb;

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk
);
    // 40 ns period
    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

/* dv/core_tb.sv */
`timescale 1ns/1ps

module core_tb;
    import core_isa_pkg::*;
    import core_cfg_pkg::*;

    localparam int STIM_WORDS   = 512;
    localparam int ACK_WAIT     = 10;
    localparam int LOAD_CYCLES  = 3;
    localparam int RESET_CYCLES = 5;

    logic               clk;
    logic               rst;
    logic               load_req;
    logic [IMEM_AW-1:0] load_addr;
    logic [XLEN-1:0]    load_data;
    logic               load_ack;
    logic [XLEN-1:0]    test;

    logic [31:0] stim [STIM_WORDS];
    int          errors;
    int          passed;
    int          tests;
    int          cycles;
    int          cycle_limit;

    clk_gen clkg (
        .clk (clk)
    );

    core dut0 (
        .clk       (clk),
        .rst       (rst),
        .load_req  (load_req),
        .load_addr (load_addr),
        .load_data (load_data),
        .load_ack  (load_ack),
        .test      (test)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // one word through the four-phase load port
    task automatic load_word(input int addr, input logic [XLEN-1:0] word);
        int waited;
        waited = 0;
        @(negedge clk);
        load_addr = IMEM_AW'(addr);
        load_data = word;
        load_req  = 1'b1;
        while (load_ack !== 1'b1 && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (load_ack !== 1'b1) begin
            $display("load_ack did not rise within %0d cycles for word %0d", ACK_WAIT, addr);
            errors++;
        end
        load_req = 1'b0;
        waited   = 0;
        while (load_ack !== 1'b0 && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (load_ack !== 1'b0) begin
            $display("load_ack did not fall within %0d cycles for word %0d", ACK_WAIT, addr);
            errors++;
        end
    endtask

    task automatic run_test(input int base);
        int              nwords;
        int              budget;
        int              a;
        logic [XLEN-1:0] expected;
        logic [XLEN-1:0] word;
        nwords   = stim[base];
        budget   = stim[base + nwords + 1];
        expected = stim[base + nwords + 2];
        rst      = 1'b1;
        // words past the program load as no-ops
        for (a = 0; a < IMEM_WORDS; a++) begin
            word = (a < nwords) ? stim[base + 1 + a] : '0;
            load_word(a, word);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        repeat (budget) @(negedge clk);
        tests++;
        if (test !== expected) begin
            $display("MISMATCH at %0t: test %0d x1 is %h, expected %h",
                     $time, tests, test, expected);
            errors++;
        end else begin
            passed++;
            $display("test %0d passed, x1 = %h", tests, test);
        end
        rst = 1'b1;
    endtask

    initial begin
        int idx;
        int budget_sum;
        int n_tests;
        rst         = 1'b1;
        load_req    = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        errors      = 0;
        passed      = 0;
        tests       = 0;
        cycles      = 0;
        cycle_limit = 0;
        $readmemh("dv/core_stim.txt", stim);

        // first pass sizes the timeout
        idx        = 0;
        budget_sum = 0;
        n_tests    = 0;
        while (idx < STIM_WORDS && !$isunknown(stim[idx]) && stim[idx] != 0) begin
            budget_sum += stim[idx + stim[idx] + 1];
            n_tests++;
            idx += stim[idx] + 3;
        end
        cycle_limit = 2 * (budget_sum + RESET_CYCLES +
                           n_tests * (IMEM_WORDS * LOAD_CYCLES + RESET_CYCLES + 1));

        repeat (RESET_CYCLES) @(negedge clk);
        idx = 0;
        while (idx < STIM_WORDS && !$isunknown(stim[idx]) && stim[idx] != 0) begin
            run_test(idx);
            idx += stim[idx] + 3;
        end
        if (n_tests == 0) begin
            $display("no test records found in the stimulus file");
            errors++;
        end

        $display("%0d tests run, %0d passed, %0d errors", tests, passed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* dv/core_stim.txt */
// record: word count, program words, cycle budget, expected x1
// all hex, a zero word count ends the list
// addi chain with a negative immediate
3 06400093 FE208093 00508093 18 0000004B
// add, sub, and, or, xor, slt
3 00700113 00C00193 003100B3 18 00000013
3 00500113 00900193 403100B3 18 FFFFFFFC
3 06C00113 03A00193 003170B3 18 00000028
3 06C00113 03A00193 003160B3 18 0000007E
3 06C00113 03A00193 003140B3 18 00000056
3 FFD00113 00200193 003120B3 18 00000001
// operands one, two and three instructions back
5 00100113 00400213 002202B3 00228333 005300B3 18 0000000B
// sw then lw of the same word
3 12300113 00202423 00802083 18 00000123
// lw x2 followed directly by add x1, x2, x2
4 32100193 00302823 01002103 002100B3 18 00000642
// write to x0 is dropped
3 03700013 000000B3 00908093 18 00000009
0

/* filelist.f */
hw/core_isa_pkg.sv
hw/core_cfg_pkg.sv
hw/instr_mem.sv
hw/decode.sv
hw/exec.sv
hw/data_ram.sv
hw/registerfile.sv
hw/core.sv
dv/clk_gen.sv
dv/core_tb.sv

/* Bender.yml */
package:
  name: core

sources:
  - files:
      - hw/core_isa_pkg.sv
      - hw/core_cfg_pkg.sv
      - hw/instr_mem.sv
      - hw/decode.sv
      - hw/exec.sv
      - hw/data_ram.sv
      - hw/registerfile.sv
      - hw/core.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/core_tb.sv
